/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module rename_core_tb -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrename_core_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS PASSED" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

/* src.f */
src/rename_pkg.sv
src/rename_table.sv
src/free_list.sv
src/reorder_buffer.sv
src/rename_core.sv
tb/rename_core_tb.sv

/* src/free_list.sv */
//####################
// Free physical registers as speculative and committed bitmaps
// Lowest free register is offered each cycle; the caller
// must never allocate from an empty list
//####################

`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
#(
  parameter int ARF_COUNT = DEFAULT_ARF_COUNT,
  parameter int PRF_COUNT = DEFAULT_PRF_COUNT
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         alloc_enable,
  output logic [$clog2(PRF_COUNT)-1:0] alloc_phys,
  input  logic                         release_enable,
  input  logic [$clog2(PRF_COUNT)-1:0] release_phys,
  input  logic [$clog2(PRF_COUNT)-1:0] commit_used_phys,
  input  logic                         flush
);

  localparam int PRF_W = $clog2(PRF_COUNT);

  logic [PRF_COUNT-1:0] spec_free;
  logic [PRF_COUNT-1:0] commit_free;
  logic [PRF_COUNT-1:0] spec_next;
  logic [PRF_COUNT-1:0] commit_next;

  // Priority encoder, lowest index wins
  always_comb begin
    alloc_phys = '0;
    for (int i = PRF_COUNT - 1; i >= 0; i--) begin
      if (spec_free[i]) begin
        alloc_phys = PRF_W'(i);
      end
    end
  end

  always_comb begin
    spec_next   = spec_free;
    commit_next = commit_free;
    if (alloc_enable) begin
      spec_next[alloc_phys] = 1'b0;
    end
    if (release_enable) begin
      spec_next[release_phys]       = 1'b1;
      commit_next[release_phys]     = 1'b1;
      commit_next[commit_used_phys] = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < PRF_COUNT; i++) begin
        spec_free[i]   <= (i >= ARF_COUNT);
        commit_free[i] <= (i >= ARF_COUNT);
      end
    end else begin
      commit_free <= commit_next;
      // Restore from the committed copy after this edge's retirement
      spec_free   <= flush ? commit_next : spec_next;
    end
  end

  // Sizing rule at the top level should make this impossible
  a_alloc_not_empty: assert property (
    @(posedge clock) disable iff (reset) alloc_enable && !flush |-> spec_free != '0
  ) else $error("free_list: allocation with no free register");

  // Old mapping of a retiring instruction must still be in use
  a_release_in_use: assert property (
    @(posedge clock) disable iff (reset) release_enable |-> !spec_free[release_phys]
  ) else $error("free_list: release of register %0d that is already free", release_phys);

endmodule

/* src/rename_core.sv */
//####################
// Register rename and in-order retirement, one wide
// Requires PRF_COUNT >= ARF_COUNT + ROB_DEPTH and a
// power-of-two ROB_DEPTH
//####################

`timescale 1ns/1ps

module rename_core
  import rename_pkg::*;
#(
  parameter int ARF_COUNT = DEFAULT_ARF_COUNT,
  parameter int PRF_COUNT = DEFAULT_PRF_COUNT,
  parameter int ROB_DEPTH = DEFAULT_ROB_DEPTH
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         dispatch,
  input  logic                         dest_valid,
  input  logic [$clog2(ARF_COUNT)-1:0] dest_arch,
  input  logic [$clog2(ARF_COUNT)-1:0] src1_arch,
  input  logic [$clog2(ARF_COUNT)-1:0] src2_arch,
  output logic                         full,
  output logic                         renamed,
  output logic [$clog2(ROB_DEPTH)-1:0] renamed_rob_index,
  output logic [$clog2(PRF_COUNT)-1:0] renamed_src1_phys,
  output logic [$clog2(PRF_COUNT)-1:0] renamed_src2_phys,
  output logic [$clog2(PRF_COUNT)-1:0] renamed_dest_phys,
  output logic [$clog2(PRF_COUNT)-1:0] renamed_dest_old,
  input  logic                         complete,
  input  logic [$clog2(ROB_DEPTH)-1:0] complete_index,
  input  logic                         flush,
  output logic                         retired,
  output logic [$clog2(ARF_COUNT)-1:0] retired_dest_arch,
  output logic [$clog2(PRF_COUNT)-1:0] retired_dest_phys
);

  localparam int PRF_W = $clog2(PRF_COUNT);
  localparam int IDX_W = $clog2(ROB_DEPTH);

  if (PRF_COUNT < ARF_COUNT + ROB_DEPTH) begin : g_prf_size_check
    $error("rename_core: PRF_COUNT must be at least ARF_COUNT + ROB_DEPTH");
  end
  if ((1 << IDX_W) != ROB_DEPTH) begin : g_rob_depth_check
    $error("rename_core: ROB_DEPTH must be a power of two");
  end

  logic             alloc_enable;
  logic [PRF_W-1:0] alloc_phys;
  logic [PRF_W-1:0] src1_phys;
  logic [PRF_W-1:0] src2_phys;
  logic [PRF_W-1:0] old_phys;
  logic [IDX_W-1:0] tail_index;
  logic             retire;
  logic             retire_dest_valid;
  logic [PRF_W-1:0] retire_free_phys;
  logic             retire_commit;

  // Only a destination takes a physical register
  assign alloc_enable  = dispatch & dest_valid;
  assign retire_commit = retire & retire_dest_valid;
  assign retired       = retire;

  rename_table #(
    .ARF_COUNT (ARF_COUNT),
    .PRF_COUNT (PRF_COUNT)
  ) i_rename_table (
    .clock         (clock),
    .reset         (reset),
    .src1_arch     (src1_arch),
    .src2_arch     (src2_arch),
    .dest_arch     (dest_arch),
    .write_enable  (alloc_enable),
    .write_phys    (alloc_phys),
    .src1_phys     (src1_phys),
    .src2_phys     (src2_phys),
    .old_phys      (old_phys),
    .commit_enable (retire_commit),
    .commit_arch   (retired_dest_arch),
    .commit_phys   (retired_dest_phys),
    .flush         (flush)
  );

  free_list #(
    .ARF_COUNT (ARF_COUNT),
    .PRF_COUNT (PRF_COUNT)
  ) i_free_list (
    .clock            (clock),
    .reset            (reset),
    .alloc_enable     (alloc_enable),
    .alloc_phys       (alloc_phys),
    .release_enable   (retire_commit),
    .release_phys     (retire_free_phys),
    .commit_used_phys (retired_dest_phys),
    .flush            (flush)
  );

  reorder_buffer #(
    .ARF_COUNT (ARF_COUNT),
    .PRF_COUNT (PRF_COUNT),
    .ROB_DEPTH (ROB_DEPTH)
  ) i_reorder_buffer (
    .clock             (clock),
    .reset             (reset),
    .allocate          (dispatch),
    .alloc_dest_valid  (dest_valid),
    .alloc_dest_arch   (dest_arch),
    .alloc_dest_phys   (alloc_phys),
    .alloc_dest_old    (old_phys),
    .tail_index        (tail_index),
    .full              (full),
    .complete          (complete),
    .complete_index    (complete_index),
    .retire            (retire),
    .retire_dest_valid (retire_dest_valid),
    .retire_dest_arch  (retired_dest_arch),
    .retire_dest_phys  (retired_dest_phys),
    .retire_free_phys  (retire_free_phys),
    .flush             (flush)
  );

  // Flush wins over a dispatch in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      renamed <= 1'b0;
    end else begin
      renamed <= dispatch & ~flush;
    end
  end

  always_ff @(posedge clock) begin
    renamed_rob_index <= tail_index;
    renamed_src1_phys <= src1_phys;
    renamed_src2_phys <= src2_phys;
    renamed_dest_phys <= alloc_phys;
    renamed_dest_old  <= old_phys;
  end

endmodule

/* src/rename_pkg.sv */
//####################
// Shared types and default sizes for the rename subsystem
// ROB depth must stay a power of two
//####################

package rename_pkg;

  // Reorder buffer slot life cycle
  typedef enum logic [1:0] {
    SLOT_EMPTY = 2'd0,
    SLOT_WAIT  = 2'd1,
    SLOT_DONE  = 2'd2
  } slot_state_t;

  // Architectural register file size
  localparam int DEFAULT_ARF_COUNT = 16;

  // Physical register file size, at least ARF plus ROB depth
  localparam int DEFAULT_PRF_COUNT = 32;

  // Reorder buffer slots
  localparam int DEFAULT_ROB_DEPTH = 8;

endpackage

/* src/rename_table.sv */
//####################
// Speculative and committed arch-to-phys maps
// Reset maps register r to physical r; flush restores
// the speculative map, including a same-cycle commit
//####################

`timescale 1ns/1ps

module rename_table
  import rename_pkg::*;
#(
  parameter int ARF_COUNT = DEFAULT_ARF_COUNT,
  parameter int PRF_COUNT = DEFAULT_PRF_COUNT
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [$clog2(ARF_COUNT)-1:0] src1_arch,
  input  logic [$clog2(ARF_COUNT)-1:0] src2_arch,
  input  logic [$clog2(ARF_COUNT)-1:0] dest_arch,
  input  logic                         write_enable,
  input  logic [$clog2(PRF_COUNT)-1:0] write_phys,
  output logic [$clog2(PRF_COUNT)-1:0] src1_phys,
  output logic [$clog2(PRF_COUNT)-1:0] src2_phys,
  output logic [$clog2(PRF_COUNT)-1:0] old_phys,
  input  logic                         commit_enable,
  input  logic [$clog2(ARF_COUNT)-1:0] commit_arch,
  input  logic [$clog2(PRF_COUNT)-1:0] commit_phys,
  input  logic                         flush
);

  localparam int PRF_W = $clog2(PRF_COUNT);

  logic [PRF_W-1:0] spec_map   [ARF_COUNT];
  logic [PRF_W-1:0] commit_map [ARF_COUNT];
  logic [PRF_W-1:0] commit_next [ARF_COUNT];

  // Lookups see the map before this cycle's write
  assign src1_phys = spec_map[src1_arch];
  assign src2_phys = spec_map[src2_arch];
  assign old_phys  = spec_map[dest_arch];

  // Committed map after this edge, also the flush source
  always_comb begin
    for (int r = 0; r < ARF_COUNT; r++) begin
      commit_next[r] = commit_map[r];
    end
    if (commit_enable) begin
      commit_next[commit_arch] = commit_phys;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < ARF_COUNT; r++) begin
        spec_map[r]   <= PRF_W'(r);
        commit_map[r] <= PRF_W'(r);
      end
    end else begin
      commit_map <= commit_next;
      if (flush) begin
        spec_map <= commit_next;
      end else if (write_enable) begin
        spec_map[dest_arch] <= write_phys;
      end
    end
  end

endmodule

/* src/reorder_buffer.sv */
//####################
// Circular reorder buffer, one allocate and one retire per cycle
// No back-pressure; caller must not allocate while full
// Flush drops every slot that has not retired
//####################

`timescale 1ns/1ps

module reorder_buffer
  import rename_pkg::*;
#(
  parameter int ARF_COUNT = DEFAULT_ARF_COUNT,
  parameter int PRF_COUNT = DEFAULT_PRF_COUNT,
  parameter int ROB_DEPTH = DEFAULT_ROB_DEPTH
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         allocate,
  input  logic                         alloc_dest_valid,
  input  logic [$clog2(ARF_COUNT)-1:0] alloc_dest_arch,
  input  logic [$clog2(PRF_COUNT)-1:0] alloc_dest_phys,
  input  logic [$clog2(PRF_COUNT)-1:0] alloc_dest_old,
  output logic [$clog2(ROB_DEPTH)-1:0] tail_index,
  output logic                         full,
  input  logic                         complete,
  input  logic [$clog2(ROB_DEPTH)-1:0] complete_index,
  output logic                         retire,
  output logic                         retire_dest_valid,
  output logic [$clog2(ARF_COUNT)-1:0] retire_dest_arch,
  output logic [$clog2(PRF_COUNT)-1:0] retire_dest_phys,
  output logic [$clog2(PRF_COUNT)-1:0] retire_free_phys,
  input  logic                         flush
);

  localparam int ARF_W = $clog2(ARF_COUNT);
  localparam int PRF_W = $clog2(PRF_COUNT);
  localparam int IDX_W = $clog2(ROB_DEPTH);

  slot_state_t slot_state [ROB_DEPTH];

  // Slot payload
  logic             slot_dest_valid [ROB_DEPTH];
  logic [ARF_W-1:0] slot_dest_arch  [ROB_DEPTH];
  logic [PRF_W-1:0] slot_dest_phys  [ROB_DEPTH];
  logic [PRF_W-1:0] slot_dest_old   [ROB_DEPTH];

  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] tail;
  logic [IDX_W:0]   count;
  logic [IDX_W:0]   count_next;

  assign tail_index = tail;
  assign full       = (count == (IDX_W + 1)'(ROB_DEPTH));

  // Head retires as soon as it is done
  assign retire            = (slot_state[head] == SLOT_DONE);
  assign retire_dest_valid = slot_dest_valid[head];
  assign retire_dest_arch  = slot_dest_arch[head];
  assign retire_dest_phys  = slot_dest_phys[head];
  assign retire_free_phys  = slot_dest_old[head];

  always_comb begin
    count_next = count;
    if (allocate) begin
      count_next = count_next + 1'b1;
    end
    if (retire) begin
      count_next = count_next - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        slot_state[i] <= SLOT_EMPTY;
      end
    end else begin
      // Completion never targets the head while it retires
      if (complete) begin
        slot_state[complete_index] <= SLOT_DONE;
      end
      if (retire) begin
        slot_state[head] <= SLOT_EMPTY;
        head             <= head + 1'b1;
      end
      if (allocate) begin
        slot_state[tail] <= SLOT_WAIT;
        tail             <= tail + 1'b1;
      end
      count <= count_next;
    end
  end

  // Payload is only meaningful while the slot state says so
  always_ff @(posedge clock) begin
    if (allocate) begin
      slot_dest_valid[tail] <= alloc_dest_valid;
      slot_dest_arch[tail]  <= alloc_dest_arch;
      slot_dest_phys[tail]  <= alloc_dest_phys;
      slot_dest_old[tail]   <= alloc_dest_old;
    end
  end

  a_no_alloc_full: assert property (
    @(posedge clock) disable iff (reset) allocate && !flush |-> !full
  ) else $error("reorder_buffer: dispatch while full");

  a_complete_waiting: assert property (
    @(posedge clock) disable iff (reset)
      complete && !flush |-> slot_state[complete_index] == SLOT_WAIT
  ) else $error("reorder_buffer: completion of slot %0d not in flight", complete_index);

endmodule

/* tb/rename_core_tb.sv */
//####################
// Testbench for rename_core at its default sizes
// A reference model steps once per falling edge; inputs come
// from a fixed-seed LCG and never dispatch into a full buffer
//####################

`timescale 1ns/1ps

module rename_core_tb
  import rename_pkg::*;
();

  localparam int ARF_COUNT      = DEFAULT_ARF_COUNT;
  localparam int PRF_COUNT      = DEFAULT_PRF_COUNT;
  localparam int ROB_DEPTH      = DEFAULT_ROB_DEPTH;
  localparam int ARF_W          = $clog2(ARF_COUNT);
  localparam int PRF_W          = $clog2(PRF_COUNT);
  localparam int IDX_W          = $clog2(ROB_DEPTH);
  localparam int PHASE_CYCLES   = 300;
  localparam int TIMEOUT_CYCLES = 4 * PHASE_CYCLES + 800;

  typedef struct packed {
    logic [IDX_W-1:0] index;
    logic             dest_valid;
    logic [ARF_W-1:0] arch;
    logic [PRF_W-1:0] phys;
    logic [PRF_W-1:0] old;
    slot_state_t      state;
  } slot_t;

  logic             clock;
  logic             reset;
  logic             dispatch;
  logic             dest_valid;
  logic [ARF_W-1:0] dest_arch;
  logic [ARF_W-1:0] src1_arch;
  logic [ARF_W-1:0] src2_arch;
  logic             full;
  logic             renamed;
  logic [IDX_W-1:0] renamed_rob_index;
  logic [PRF_W-1:0] renamed_src1_phys;
  logic [PRF_W-1:0] renamed_src2_phys;
  logic [PRF_W-1:0] renamed_dest_phys;
  logic [PRF_W-1:0] renamed_dest_old;
  logic             complete;
  logic [IDX_W-1:0] complete_index;
  logic             flush;
  logic             retired;
  logic [ARF_W-1:0] retired_dest_arch;
  logic [PRF_W-1:0] retired_dest_phys;

  // Reference model state
  logic [PRF_W-1:0]     spec_map   [ARF_COUNT];
  logic [PRF_W-1:0]     commit_map [ARF_COUNT];
  logic [PRF_COUNT-1:0] spec_free;
  logic [PRF_COUNT-1:0] commit_free;
  slot_t                slots [$];
  logic [IDX_W-1:0]     model_tail;

  // Expected outputs between two rising edges
  logic             exp_renamed;
  logic             exp_dest_valid;
  logic [IDX_W-1:0] exp_rob_index;
  logic [PRF_W-1:0] exp_src1;
  logic [PRF_W-1:0] exp_src2;
  logic [PRF_W-1:0] exp_dest_phys;
  logic [PRF_W-1:0] exp_dest_old;
  logic             exp_retired;
  logic             exp_retire_valid;
  logic [ARF_W-1:0] exp_retired_arch;
  logic [PRF_W-1:0] exp_retired_phys;
  logic             exp_full;

  int          error_count  = 0;
  int          rename_count = 0;
  int          retire_count = 0;
  int          flush_count  = 0;
  int          reuse_count  = 0;
  int          full_count   = 0;
  int          cycle_count  = 0;
  int unsigned lcg_state    = 15264;
  string       test_name    = "reset";

  rename_core i_dut (.*);

  always #4 clock = ~clock;

  function automatic int unsigned next_random(int unsigned range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % range;
  endfunction

  function automatic logic [PRF_W-1:0] lowest_free();
    for (int i = 0; i < PRF_COUNT; i++) begin
      if (spec_free[i]) begin
        return PRF_W'(i);
      end
    end
    return '0;
  endfunction

  function automatic void report_mismatch(string signal_name, int expected, int actual);
    error_count++;
    $display("error %s %s: expected %0d actual %0d", test_name, signal_name, expected, actual);
  endfunction

  task automatic reset_model();
    for (int r = 0; r < ARF_COUNT; r++) begin
      spec_map[r]   = PRF_W'(r);
      commit_map[r] = PRF_W'(r);
    end
    for (int i = 0; i < PRF_COUNT; i++) begin
      spec_free[i]   = (i >= ARF_COUNT);
      commit_free[i] = (i >= ARF_COUNT);
    end
    slots.delete();
    model_tail  = '0;
    exp_renamed = 1'b0;
    exp_retired = 1'b0;
    exp_full    = 1'b0;
  endtask

  // Apply the rising edge just passed, using the inputs still on the pins
  task automatic update_model();
    slot_t            entry;
    logic [PRF_W-1:0] new_phys;
    new_phys       = lowest_free();
    exp_renamed    = dispatch && !flush;
    exp_dest_valid = dest_valid;
    exp_rob_index  = model_tail;
    exp_src1       = spec_map[src1_arch];
    exp_src2       = spec_map[src2_arch];
    exp_dest_phys  = new_phys;
    exp_dest_old   = spec_map[dest_arch];
    if (exp_retired) begin
      entry = slots.pop_front();
      retire_count++;
      if (entry.dest_valid) begin
        commit_map[entry.arch]  = entry.phys;
        commit_free[entry.old]  = 1'b1;
        commit_free[entry.phys] = 1'b0;
        spec_free[entry.old]    = 1'b1;
      end
    end
    if (flush) begin
      if (slots.size() > 0) begin
        flush_count++;
      end
      slots.delete();
      model_tail = '0;
      spec_map   = commit_map;
      spec_free  = commit_free;
    end else begin
      if (complete) begin
        foreach (slots[i]) begin
          if (slots[i].index == complete_index) begin
            entry       = slots[i];
            entry.state = SLOT_DONE;
            slots[i]    = entry;
          end
        end
      end
      if (dispatch) begin
        entry.index      = model_tail;
        entry.dest_valid = dest_valid;
        entry.arch       = dest_arch;
        entry.phys       = new_phys;
        entry.old        = spec_map[dest_arch];
        entry.state      = SLOT_WAIT;
        slots.push_back(entry);
        model_tail = model_tail + IDX_W'(1);
        rename_count++;
        if (dest_valid) begin
          spec_free[new_phys] = 1'b0;
          spec_map[dest_arch] = new_phys;
          if (int'(new_phys) < ARF_COUNT) begin
            reuse_count++;
          end
        end
      end
    end
    exp_full         = (slots.size() == ROB_DEPTH);
    exp_retired      = (slots.size() > 0) && (slots[0].state == SLOT_DONE);
    exp_retire_valid = exp_retired && slots[0].dest_valid;
    if (exp_retired) begin
      exp_retired_arch = slots[0].arch;
      exp_retired_phys = slots[0].phys;
    end
    if (exp_full) begin
      full_count++;
    end
  endtask

  task automatic advance_cycle(int dispatch_pct, int complete_pct, int flush_pct);
    int waiting [$];
    @(negedge clock);
    update_model();
    dispatch   = (slots.size() < ROB_DEPTH) && (next_random(100) < dispatch_pct);
    dest_valid = (next_random(4) != 0);
    dest_arch  = ARF_W'(next_random(ARF_COUNT));
    src1_arch  = ARF_W'(next_random(ARF_COUNT));
    src2_arch  = ARF_W'(next_random(ARF_COUNT));
    foreach (slots[i]) begin
      if (slots[i].state == SLOT_WAIT) begin
        waiting.push_back(int'(slots[i].index));
      end
    end
    complete = (waiting.size() > 0) && (next_random(100) < complete_pct);
    if (complete) begin
      complete_index = IDX_W'(waiting[next_random(waiting.size())]);
    end else begin
      complete_index = '0;
    end
    flush = (next_random(100) < flush_pct);
  endtask

  a_renamed: assert property (@(posedge clock) disable iff (reset) renamed == exp_renamed)
    else report_mismatch("renamed", int'(exp_renamed), int'($sampled(renamed)));
  a_rob_index: assert property (@(posedge clock) disable iff (reset)
    exp_renamed |-> renamed_rob_index == exp_rob_index)
    else report_mismatch("rob_index", int'(exp_rob_index), int'($sampled(renamed_rob_index)));
  a_src1: assert property (@(posedge clock) disable iff (reset)
    exp_renamed |-> renamed_src1_phys == exp_src1)
    else report_mismatch("src1_phys", int'(exp_src1), int'($sampled(renamed_src1_phys)));
  a_src2: assert property (@(posedge clock) disable iff (reset)
    exp_renamed |-> renamed_src2_phys == exp_src2)
    else report_mismatch("src2_phys", int'(exp_src2), int'($sampled(renamed_src2_phys)));
  a_dest_phys: assert property (@(posedge clock) disable iff (reset)
    exp_renamed && exp_dest_valid |-> renamed_dest_phys == exp_dest_phys)
    else report_mismatch("dest_phys", int'(exp_dest_phys), int'($sampled(renamed_dest_phys)));
  a_dest_old: assert property (@(posedge clock) disable iff (reset)
    exp_renamed && exp_dest_valid |-> renamed_dest_old == exp_dest_old)
    else report_mismatch("dest_old", int'(exp_dest_old), int'($sampled(renamed_dest_old)));
  a_retired: assert property (@(posedge clock) disable iff (reset) retired == exp_retired)
    else report_mismatch("retired", int'(exp_retired), int'($sampled(retired)));
  a_retired_arch: assert property (@(posedge clock) disable iff (reset)
    exp_retire_valid |-> retired_dest_arch == exp_retired_arch)
    else report_mismatch("retired_arch", int'(exp_retired_arch), int'($sampled(retired_dest_arch)));
  a_retired_phys: assert property (@(posedge clock) disable iff (reset)
    exp_retire_valid |-> retired_dest_phys == exp_retired_phys)
    else report_mismatch("retired_phys", int'(exp_retired_phys), int'($sampled(retired_dest_phys)));
  a_full: assert property (@(posedge clock) disable iff (reset) full == exp_full)
    else report_mismatch("full", int'(exp_full), int'($sampled(full)));

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with %0d slots still in flight",
               TIMEOUT_CYCLES, slots.size());
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch       = 1'b0;
    dest_valid     = 1'b0;
    dest_arch      = '0;
    src1_arch      = '0;
    src2_arch      = '0;
    complete       = 1'b0;
    complete_index = '0;
    flush          = 1'b0;
    reset_model();
    repeat (4) @(negedge clock);
    reset = 1'b0;
    // No completions at first, so the buffer fills and dispatch stalls
    test_name = "fill_and_full";
    repeat (20) advance_cycle(100, 0, 0);
    repeat (PHASE_CYCLES - 20) advance_cycle(70, 40, 0);
    test_name = "random_completion";
    repeat (PHASE_CYCLES) advance_cycle(60, 60, 0);
    test_name = "flush_recovery";
    repeat (PHASE_CYCLES) advance_cycle(70, 35, 4);
    test_name = "full_pressure";
    repeat (PHASE_CYCLES) advance_cycle(100, 25, 0);
    test_name = "drain";
    while (slots.size() > 0) begin
      advance_cycle(0, 100, 0);
    end
    repeat (2) advance_cycle(0, 0, 0);
    if (full_count == 0) begin
      error_count++;
      $display("The reorder buffer never reported full");
    end
    if (flush_count == 0) begin
      error_count++;
      $display("No flush happened while slots were in flight");
    end
    if (reuse_count == 0) begin
      error_count++;
      $display("No retired register was ever allocated again");
    end
    $display("errors %0d, renames %0d, retirements %0d, flushes in flight %0d",
             error_count, rename_count, retire_count, flush_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
